/* rtl/alu_cfg.svh */
/*
 * Build-time sizes for the ALU datapath and its command buffer.
 * Included by both packages and by modules that size logic from these values.
 */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width
`define ALU_WIDTH 32

// Raw opcode field in a request, wide enough for the load immediate codes 32 and 33
`define OPCODE_WIDTH 6

// Commands that may sit between decoder and execute unit
`define CMD_FIFO_DEPTH 4

`endif

/* rtl/aluOpPkg.sv */
/*
 * Operation types for the ALU: the decoded operation set, the raw request
 * as it arrives on the request handshake, and the decoded command that
 * travels through the command buffer.
 */
`include "alu_cfg.svh"

package aluOpPkg;

	// Decoded operation, filled to exactly 16 codes
	typedef enum logic [3:0] {
		OP_NOP,     // Result 0, flags kept
		OP_ADD,     // Add, also load base with index
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_NEG,     // Two's complement of RA
		OP_XOR,
		OP_COMP,    // One's complement of RA
		OP_LSR,
		OP_ASR,     // Sign fills from the top
		OP_LSL,
		OP_ROR,     // Through carry
		OP_ROL,     // Through carry
		OP_MOVE,    // Pass RA
		OP_LDI,     // Pass RB, the immediate
		OP_ILLEGAL  // Unknown raw opcode
	} aluOp;

	// Raw request from the outside
	typedef struct packed {
		logic [`OPCODE_WIDTH-1:0] opcode;
		logic [`ALU_WIDTH-1:0]    ra;
		logic [`ALU_WIDTH-1:0]    rb;
	} aluRequest;

	// Command after decode
	typedef struct packed {
		aluOp                  op;
		logic [`ALU_WIDTH-1:0] ra;
		logic [`ALU_WIDTH-1:0] rb;
	} aluCmd;

endpackage

/* rtl/ccrPkg.sv */
/*
 * Condition code types: the flag set held by the execute unit and the
 * result that leaves on the result handshake together with its flags.
 */
`include "alu_cfg.svh"

package ccrPkg;

	// Flag order follows the CCR layout, INR down to C
	typedef struct packed {
		logic inr;  // Instruction not recognized
		logic n;    // Negative, bit 31 of rz
		logic z;    // Zero result
		logic v;    // Signed overflow
		logic c;    // Carry, also the rotate bit
	} ccrFlags;

	// Result word plus the CCR after this command
	typedef struct packed {
		logic [`ALU_WIDTH-1:0] rz;
		ccrFlags               flags;
	} aluResult;

endpackage

/* rtl/opDecoder.sv */
/*
 * Request side of the ALU. Accepts raw requests on a four-phase req/ack
 * handshake, maps the raw opcode to a decoded operation and pushes the
 * command into the command buffer. Holds off opAck while the buffer is full.
 */
`timescale 1ns/1ps

module opDecoder import aluOpPkg::*; (
	input  logic      Clock,
	input  logic      rst,
	input  logic      opReq,    // Request from the outside
	input  aluRequest opIn,     // Stable while opReq is high
	output logic      opAck,
	input  logic      cmdFull,  // Buffer back-pressure
	output logic      cmdPush,
	output aluCmd     cmdIn
);

	typedef enum logic [1:0] {
		IDLE,       // Waiting for opReq
		ACKED,      // opAck high until opReq drops
		WAIT_DROP   // opAck low again, return to zero completes
	} decState;

	decState state;
	aluOp    decodedOp;

	// Opcode map, two raw codes each for ADD, LSL and LDI
	always_comb begin
		case (opIn.opcode)
			0:       decodedOp = OP_NOP;
			1, 15:   decodedOp = OP_ADD;   // 15 is load base with index
			2:       decodedOp = OP_SUB;
			3:       decodedOp = OP_AND;
			4:       decodedOp = OP_OR;
			5:       decodedOp = OP_NEG;
			6:       decodedOp = OP_XOR;
			7:       decodedOp = OP_COMP;
			8:       decodedOp = OP_LSR;
			9:       decodedOp = OP_ASR;
			10, 11:  decodedOp = OP_LSL;   // LSL and ASL behave alike
			12:      decodedOp = OP_ROR;
			13:      decodedOp = OP_ROL;
			14:      decodedOp = OP_MOVE;
			32, 33:  decodedOp = OP_LDI;   // Signed and unsigned immediate
			default: decodedOp = OP_ILLEGAL;
		endcase
	end

	assign cmdIn = '{op: decodedOp, ra: opIn.ra, rb: opIn.rb};

	// Push on the same edge that takes the request
	assign cmdPush = (state == IDLE) && opReq && !cmdFull;
	assign opAck   = (state == ACKED);

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (cmdPush) begin
						state <= ACKED;
					end
				end
				ACKED: begin
					if (!opReq) begin
						state <= WAIT_DROP;  // Ack falls on this edge
					end
				end
				WAIT_DROP: state <= IDLE;  // Requester sees opAck low first
				default:   state <= IDLE;
			endcase
		end
	end

endmodule

/* rtl/cmdFifo.sv */
/*
 * Circular buffer of decoded commands between decoder and execute unit.
 * Head is visible at cmdOut while cmdEmpty is low; push and pop may
 * happen on the same edge. DEPTH need not be a power of two.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module cmdFifo import aluOpPkg::*; #(
	parameter int DEPTH = `CMD_FIFO_DEPTH
) (
	input  logic  Clock,
	input  logic  rst,
	input  logic  cmdPush,
	input  aluCmd cmdIn,
	output logic  cmdFull,
	input  logic  cmdPop,
	output aluCmd cmdOut,   // Head of the buffer
	output logic  cmdEmpty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	aluCmd            mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;  // Entries held
	logic             doPush;
	logic             doPop;

	// Wrap at DEPTH, not at the pointer width
	function automatic logic [PTR_W-1:0] incPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush   = cmdPush && !cmdFull;
	assign doPop    = cmdPop && !cmdEmpty;
	assign cmdFull  = (count == CNT_W'(DEPTH));
	assign cmdEmpty = (count == '0);
	assign cmdOut   = mem[rdPtr];

	always_ff @(posedge Clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= incPtr(wrPtr);
			if (doPop) rdPtr <= incPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (doPush) mem[wrPtr] <= cmdIn;
	end

endmodule

/* rtl/aluExecute.sv */
/*
 * Execute side of the ALU. Pops one command at a time, computes rz and the
 * new condition codes, and offers the result on a four-phase req/ack
 * handshake. The CCR persists across commands; rotates use its carry.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module aluExecute import aluOpPkg::*, ccrPkg::*; (
	input  logic     Clock,
	input  logic     rst,
	input  logic     cmdEmpty,
	input  aluCmd    cmdOut,    // Head of the command buffer
	output logic     cmdPop,
	output logic     resReq,
	output aluResult resOut,    // Stable from resReq rise to resAck fall
	input  logic     resAck
);

	localparam int MSB = `ALU_WIDTH - 1;

	typedef enum logic [1:0] {
		IDLE,       // Free to take the next command
		HOLD,       // resReq high, waiting for resAck
		WAIT_DROP   // Waiting for resAck to fall
	} exeState;

	exeState      state;
	ccrFlags      ccr;       // Condition code register
	ccrFlags      nextCcr;
	logic [MSB:0] rzReg;
	logic [MSB:0] nextRz;
	logic [MSB:0] ra;
	logic [MSB:0] rb;
	logic [MSB+1:0] sum;     // Extra bit holds the carry out

	assign ra  = cmdOut.ra;
	assign rb  = cmdOut.rb;
	assign sum = {1'b0, ra} + {1'b0, rb};

	assign cmdPop = (state == IDLE) && !cmdEmpty;
	assign resReq = (state == HOLD);
	assign resOut = '{rz: rzReg, flags: ccr};

	always_comb begin
		nextRz  = '0;
		nextCcr = ccr;  // Flags not touched below keep their value
		case (cmdOut.op)
			OP_ADD: begin
				nextRz    = sum[MSB:0];
				nextCcr.c = sum[MSB+1];
				// Like signs in, other sign out
				nextCcr.v = (ra[MSB] == rb[MSB]) && (nextRz[MSB] != ra[MSB]);
			end
			OP_SUB: begin
				nextRz    = ra - rb;
				nextCcr.v = (ra[MSB] != rb[MSB]) && (nextRz[MSB] != ra[MSB]);
			end
			OP_NEG: begin
				nextRz    = -ra;
				nextCcr.v = ra[MSB] && nextRz[MSB];  // Only the most negative value
			end
			OP_AND:  nextRz = ra & rb;
			OP_OR:   nextRz = ra | rb;
			OP_XOR:  nextRz = ra ^ rb;
			OP_COMP: nextRz = ~ra;
			OP_LSR: begin
				nextRz    = {1'b0, ra[MSB:1]};
				nextCcr.c = ra[0];
			end
			OP_ASR: begin
				nextRz    = {ra[MSB], ra[MSB:1]};  // Sign kept
				nextCcr.c = ra[0];
			end
			OP_LSL: begin
				nextRz    = {ra[MSB-1:0], 1'b0};
				nextCcr.c = ra[MSB];
			end
			OP_ROR: begin
				nextRz    = {ccr.c, ra[MSB:1]};    // Old carry into the top
				nextCcr.c = ra[0];
			end
			OP_ROL: begin
				nextRz    = {ra[MSB-1:0], ccr.c};  // Old carry into bit 0
				nextCcr.c = ra[MSB];
			end
			OP_MOVE:    nextRz = ra;
			OP_LDI:     nextRz = rb;
			OP_ILLEGAL: nextCcr.inr = 1'b1;      // rz stays 0
			default:    nextRz = '0;             // NOP, every flag kept
		endcase

		// Valid operations refresh INR, Z and N
		if (cmdOut.op != OP_NOP && cmdOut.op != OP_ILLEGAL) begin
			nextCcr.inr = 1'b0;
			nextCcr.z   = (nextRz == '0);
			nextCcr.n   = nextRz[MSB];
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= IDLE;
			ccr   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cmdPop) begin
						ccr   <= nextCcr;  // CCR changes only on a pop
						state <= HOLD;
					end
				end
				HOLD: begin
					if (resAck) state <= WAIT_DROP;  // resReq falls here
				end
				WAIT_DROP: begin
					if (!resAck) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Result word captured with the pop
	always_ff @(posedge Clock) begin
		if (cmdPop) rzReg <= nextRz;
	end

endmodule

/* rtl/aluTop.sv */
/*
 * ALU top level. Requests enter through the decoder, wait in the command
 * buffer and leave through the execute unit in request order.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module aluTop import aluOpPkg::*, ccrPkg::*; (
	input  logic      Clock,
	input  logic      rst,
	input  logic      opReq,
	input  aluRequest opIn,
	output logic      opAck,
	output logic      resReq,
	output aluResult  resOut,
	input  logic      resAck
);

	logic  cmdPush;
	logic  cmdFull;
	logic  cmdPop;
	logic  cmdEmpty;
	aluCmd cmdIn;   // Decoder to buffer
	aluCmd cmdOut;  // Buffer head to execute

	opDecoder i_decoder (
		.Clock(Clock), .rst(rst),
		.opReq(opReq), .opIn(opIn), .opAck(opAck),
		.cmdFull(cmdFull), .cmdPush(cmdPush), .cmdIn(cmdIn)
	);

	cmdFifo #(.DEPTH(`CMD_FIFO_DEPTH)) i_fifo (
		.Clock(Clock), .rst(rst),
		.cmdPush(cmdPush), .cmdIn(cmdIn), .cmdFull(cmdFull),
		.cmdPop(cmdPop), .cmdOut(cmdOut), .cmdEmpty(cmdEmpty)
	);

	aluExecute i_execute (
		.Clock(Clock), .rst(rst),
		.cmdEmpty(cmdEmpty), .cmdOut(cmdOut), .cmdPop(cmdPop),
		.resReq(resReq), .resOut(resOut), .resAck(resAck)
	);

endmodule

/* verification/aluTb.sv */
/*
 * Directed testbench for aluTop. Drives both four-phase handshakes and
 * checks rz and the CCR of every result against a flag model kept here.
 * Compile with verilog.f and run aluTb as the top module.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module aluTb import aluOpPkg::*, ccrPkg::*; ();

	localparam int W  = `ALU_WIDTH;
	localparam int OW = `OPCODE_WIDTH;
	localparam int MAX_CYCLES = 5000;  // About 150 transactions of up to 20 cycles each with margin

	logic      clock;
	logic      rst;
	logic      opReq;
	aluRequest opIn;
	logic      opAck;
	logic      resReq;
	aluResult  resOut;
	logic      resAck;

	ccrFlags     modelFlags;  // Expected CCR after the last modeled command
	aluResult    expQ[$];     // Expected results in request order
	int          cycleCount;
	int          sentCount;
	int unsigned seedResult;

	aluTop i_dut (
		.Clock(clock), .rst(rst),
		.opReq(opReq), .opIn(opIn), .opAck(opAck),
		.resReq(resReq), .resOut(resOut), .resAck(resAck)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;  // 4 ns period
	end

	// Watchdog on the whole run
	initial begin
		cycleCount = 0;
		while (cycleCount < MAX_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: no finish within %0d cycles, a handshake is stuck", MAX_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	task automatic check(input string name, input logic [W-1:0] actual,
			input logic [W-1:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Flag model that advances modelFlags by one command
	function automatic aluResult predict(input logic [OW-1:0] opc, input logic [W-1:0] a,
			input logic [W-1:0] b);
		logic [W:0] wide;
		logic       valid;
		aluResult   r;
		valid   = 1'b1;
		r.rz    = '0;
		r.flags = modelFlags;
		case (opc)
			0: valid = 1'b0;  // NOP keeps every flag
			1, 15: begin
				wide      = {1'b0, a} + {1'b0, b};
				r.rz      = wide[W-1:0];
				r.flags.c = wide[W];
				wide      = {a[W-1], a} + {b[W-1], b};  // Sign-extended sum
				r.flags.v = wide[W] ^ wide[W-1];
			end
			2: begin
				wide      = {a[W-1], a} - {b[W-1], b};
				r.rz      = wide[W-1:0];
				r.flags.v = wide[W] ^ wide[W-1];
			end
			5: begin
				r.rz      = '0 - a;
				r.flags.v = (a == {1'b1, {(W-1){1'b0}}});  // Most negative has no positive twin
			end
			3:  r.rz = a & b;
			4:  r.rz = a | b;
			6:  r.rz = a ^ b;
			7:  r.rz = ~a;
			8: begin
				r.rz      = a >> 1;
				r.flags.c = a[0];
			end
			9: begin
				r.rz      = $signed(a) >>> 1;
				r.flags.c = a[0];
			end
			10, 11: begin
				r.rz      = a << 1;
				r.flags.c = a[W-1];
			end
			12: begin
				r.rz      = {modelFlags.c, a[W-1:1]};  // Previous carry on top
				r.flags.c = a[0];
			end
			13: begin
				r.rz      = {a[W-2:0], modelFlags.c};
				r.flags.c = a[W-1];
			end
			14:     r.rz = a;
			32, 33: r.rz = b;
			default: begin
				valid       = 1'b0;
				r.flags.inr = 1'b1;
			end
		endcase
		if (valid) begin
			r.flags.inr = 1'b0;
			r.flags.z   = (r.rz == '0);
			r.flags.n   = r.rz[W-1];
		end
		modelFlags = r.flags;
		return r;
	endfunction

	// Four-phase request handshake
	task automatic sendOp(input logic [OW-1:0] opc, input logic [W-1:0] a, input logic [W-1:0] b);
		@(posedge clock);
		opIn  <= '{opcode: opc, ra: a, rb: b};
		opReq <= 1'b1;
		@(posedge clock);
		while (!opAck) @(posedge clock);
		opReq <= 1'b0;
		@(posedge clock);
		while (opAck) @(posedge clock);
	endtask

	// Result handshake with resOut taken while resReq is high
	task automatic getResult(output aluResult r);
		@(posedge clock);
		while (!resReq) @(posedge clock);
		r = resOut;
		resAck <= 1'b1;
		@(posedge clock);
		while (resReq) @(posedge clock);
		resAck <= 1'b0;
	endtask

	task automatic compareResult(input aluResult got, input aluResult exp);
		check("resOut.rz", got.rz, exp.rz);
		check("resOut.flags", W'(got.flags), W'(exp.flags));
	endtask

	task automatic runOp(input logic [OW-1:0] opc, input logic [W-1:0] a, input logic [W-1:0] b);
		aluResult exp;
		aluResult got;
		exp = predict(opc, a, b);
		sendOp(opc, a, b);
		getResult(got);
		compareResult(got, exp);
	endtask

	task automatic resetState();
		for (int i = 0; i < 4; i++) begin
			@(posedge clock);
			if (i > 0) begin  // First edge still shows power-up values
				check("opAck", W'(opAck), '0);
				check("resReq", W'(resReq), '0);
			end
		end
		rst <= 1'b0;
		repeat (2) @(posedge clock);
		check("opAck", W'(opAck), '0);
		check("resReq", W'(resReq), '0);
		runOp(0, 32'h1234_5678, 32'h9abc_def0);  // Reset CCR shows through a NOP
		runOp(1, 32'h0000_0005, 32'h0000_0003);
	endtask

	task automatic arithOps();
		logic [W-1:0] corners [4];
		corners = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 32'hffff_ffff};
		foreach (corners[i]) begin
			runOp(5, corners[i], '0);
			foreach (corners[j]) begin
				runOp(1, corners[i], corners[j]);
				runOp(2, corners[i], corners[j]);
			end
		end
		repeat (4) begin
			runOp(1, $urandom, $urandom);
			runOp(15, $urandom, $urandom);  // Load base with index
			runOp(2, $urandom, $urandom);
			runOp(5, $urandom, $urandom);
		end
	endtask

	task automatic logicOps();
		logic [OW-1:0] ops [7];
		ops = '{3, 4, 6, 7, 14, 32, 33};
		foreach (ops[i]) begin
			repeat (3) runOp(ops[i], $urandom, $urandom);
		end
	endtask

	task automatic shiftChain();
		logic [OW-1:0] chain [8];
		chain = '{8, 12, 9, 13, 10, 12, 11, 13};  // Each rotate follows a carry producer
		repeat (3) begin
			foreach (chain[i]) runOp(chain[i], $urandom, $urandom);
		end
		runOp(8, 32'h0000_0001, '0);   // Leaves carry 1
		runOp(12, 32'h0000_0000, '0);  // Carry lands in bit 31
		runOp(13, 32'h8000_0000, '0);  // Zero result and carry 1 again
	endtask

	task automatic nopAndIllegal();
		runOp(1, 32'h8000_0000, 32'h8000_0000);  // Sets c, v and z
		runOp(0, $urandom, $urandom);
		runOp(16, $urandom, $urandom);
		runOp(63, $urandom, $urandom);
		runOp(0, $urandom, $urandom);            // inr survives a NOP
		runOp(2, 32'h0000_0005, 32'h0000_0005);  // Valid op clears inr
	endtask

	task automatic backpressureOrder();
		logic [OW-1:0] ops [6];
		logic [W-1:0]  raList [6];
		logic [W-1:0]  rbList [6];
		aluResult      got;
		aluResult      exp;
		ops = '{1, 13, 2, 8, 6, 12};
		foreach (raList[i]) begin
			raList[i] = $urandom;
			rbList[i] = $urandom;
		end
		sentCount = 0;
		fork
			begin
				foreach (ops[i]) begin
					expQ.push_back(predict(ops[i], raList[i], rbList[i]));
					sendOp(ops[i], raList[i], rbList[i]);
					sentCount++;
				end
			end
			begin
				wait (sentCount == 5);
				repeat (8) @(posedge clock);  // One in execute, four buffered, sixth waits
				check("opAck", W'(opAck), '0);
				check("sentCount", W'(sentCount), 5);
				repeat (6) begin
					getResult(got);
					exp = expQ.pop_front();
					compareResult(got, exp);
				end
			end
		join
	endtask

	initial begin
		seedResult = $urandom(32'h93b5);
		rst        = 1'b1;
		opReq      = 1'b0;
		opIn       = '0;
		resAck     = 1'b0;
		modelFlags = '0;
		sentCount  = 0;
		resetState();
		arithOps();
		logicOps();
		shiftChain();
		nopAndIllegal();
		backpressureOrder();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/aluOpPkg.sv
rtl/ccrPkg.sv
rtl/opDecoder.sv
rtl/cmdFifo.sv
rtl/aluExecute.sv
rtl/aluTop.sv
verification/aluTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module aluTb -o aluSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/aluSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
